// ==== Bender.yml ====
package:
  name: tt_um_addon

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/mag_pkg.sv
      - hw/mag_square_sum.sv
      - hw/mag_root_stage.sv
      - hw/mag_isqrt.sv
      - hw/tt_um_addon.sv

  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/mag_assertions.sv
      - verif/tb_tt_um_addon.sv

// ==== hw/mag_isqrt.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mag_settings.svh"

module mag_isqrt (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire mag_pkg::sumsq_t    sumsq,  // From the square stage
    output logic [`MAG_ROOT_W-1:0]  root    // floor(sqrt(sum)), 8 cycles later
);

    // Index k holds the state entering the stage for bit k-1
    // Top entry is the unregistered seed, entry 0 the final state
    mag_pkg::root_state_t chain [`MAG_ROOT_W:0];

    // Seed, whole sum left to cover and no root bits yet
    assign chain[`MAG_ROOT_W].rem  = sumsq.sum;
    assign chain[`MAG_ROOT_W].root = '0;

    // MSB first, each stage one cycle
    for (genvar g = `MAG_ROOT_W - 1; g >= 0; g--) begin : g_stage
        mag_root_stage #(
            .bit_index (g)
        ) mag_root_stage_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .state_in  (chain[g+1]),
            .state_out (chain[g])
        );
    end

    // Remainder at the end is dropped, only the root leaves
    assign root = chain[0].root;

endmodule

`default_nettype wire

// ==== hw/mag_pkg.sv ====
`include "mag_settings.svh"

package mag_pkg;

    // Square stage to root chain
    typedef struct packed {
        logic [`MAG_SUM_W-1:0] sum;    // x^2 + y^2, full width
    } sumsq_t;

    // Carried from one root stage to the next
    typedef struct packed {
        logic [`MAG_SUM_W-1:0]  rem;   // Sum minus root^2
        logic [`MAG_ROOT_W-1:0] root;  // Bits decided so far
    } root_state_t;

    // Root stage zero value, also the reset value
    localparam root_state_t ROOT_STATE_ZERO = '{
        rem:  '0,
        root: '0
    };

endpackage

// ==== hw/mag_root_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mag_settings.svh"

module mag_root_stage #(
    parameter int bit_index = 0   // Root bit decided here, 0..7
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire mag_pkg::root_state_t state_in,   // From the stage above
    output mag_pkg::root_state_t    state_out   // Registered, one bit more decided
);

    localparam int pad_w = `MAG_SUM_W - `MAG_ROOT_W;  // Root to rem width

    // Bit this stage may set in the root
    localparam logic [`MAG_ROOT_W-1:0] bit_mask = `MAG_ROOT_W'(1) << bit_index;

    // Square of 2^bit_index at remainder width
    localparam logic [`MAG_SUM_W-1:0] bit_sq = `MAG_SUM_W'(1) << (2 * bit_index);

    logic [`MAG_SUM_W-1:0] root_ext;  // Partial root, widened
    logic [`MAG_SUM_W-1:0] trial;     // Growth of root^2 if bit set
    logic                  take;      // Bit fits under the remainder
    mag_pkg::root_state_t  state_d;   // Next state
    mag_pkg::root_state_t  state_q;   // Stage register

    if (bit_index < 0 || bit_index >= `MAG_ROOT_W) begin : g_bad_index
        $error("mag_root_stage bit_index out of range");
    end

    assign root_ext = {{pad_w{1'b0}}, state_in.root};

    // (2*root + 2^i) * 2^i, built from shifts only
    assign trial = (root_ext << (bit_index + 1)) + bit_sq;

    // Restoring step, keep the bit if rem stays non-negative
    assign take = (trial <= state_in.rem);

    always_comb begin
        state_d = state_in;                         // Pass through by default
        if (take) begin
            state_d.rem  = state_in.rem - trial;    // Pay for the new bit
            state_d.root = state_in.root | bit_mask;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= mag_pkg::ROOT_STATE_ZERO;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_out = state_q;

endmodule

`default_nettype wire

// ==== hw/mag_settings.svh ====
`ifndef MAG_SETTINGS_SVH
`define MAG_SETTINGS_SVH

// Vector length pipeline sizing

`define MAG_IN_W    8   // Width of x and y
`define MAG_SUM_W   17  // x^2 + y^2 without wrap
`define MAG_ROOT_W  8   // Root width, also root stage count

// Square stage plus one cycle per root bit
`define MAG_LATENCY 9   // Sample edge to uo_out

`endif

// ==== hw/mag_square_sum.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mag_settings.svh"

module mag_square_sum (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [`MAG_IN_W-1:0] x,     // First component
    input  wire logic [`MAG_IN_W-1:0] y,     // Second component
    output mag_pkg::sumsq_t        sumsq   // Registered x^2 + y^2
);

    localparam int sq_w  = 2 * `MAG_IN_W;          // One square, 16 bits
    localparam int pad_w = `MAG_SUM_W - sq_w;      // Headroom for the carry

    logic [sq_w-1:0]       sq_x;     // x^2, combinational
    logic [sq_w-1:0]       sq_y;     // y^2, combinational
    logic [`MAG_SUM_W-1:0] sum_d;    // Next sum, carry kept
    mag_pkg::sumsq_t       sumsq_q;  // Stage register

    // Square by shift and add
    // One partial product per set bit of the operand
    function automatic logic [sq_w-1:0] square_sa(
        input logic [`MAG_IN_W-1:0] v
    );
        logic [sq_w-1:0] acc;       // Running sum of partials
        logic [sq_w-1:0] v_ext;     // Operand at product width
        acc   = '0;
        v_ext = {{`MAG_IN_W{1'b0}}, v};
        for (int b = 0; b < `MAG_IN_W; b++) begin
            if (v[b]) begin
                acc = acc + (v_ext << b);  // Add v * 2^b
            end
        end
        return acc;
    endfunction

    assign sq_x = square_sa(x);
    assign sq_y = square_sa(y);

    // Widen before the add so 255^2 + 255^2 does not wrap
    assign sum_d = {{pad_w{1'b0}}, sq_x} + {{pad_w{1'b0}}, sq_y};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sumsq_q <= '0;              // Flushed sum is zero
        end else begin
            sumsq_q.sum <= sum_d;       // New pair every cycle
        end
    end

    assign sumsq = sumsq_q;

endmodule

`default_nettype wire

// ==== hw/tt_um_addon.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mag_settings.svh"

module tt_um_addon (
    input  wire logic [7:0] ui_in,    // x component
    output logic      [7:0] uo_out,   // Vector length, saturated
    input  wire logic [7:0] uio_in,   // y component
    output logic      [7:0] uio_out,  // Unused, all uio are inputs
    output logic      [7:0] uio_oe,   // All zero, input direction
    input  wire logic       ena,      // Not needed
    input  wire logic       clk,
    input  wire logic       rst_n
);

    mag_pkg::sumsq_t        sumsq;     // Square stage to root chain
    logic [`MAG_ROOT_W-1:0] root;      // Chain result

    // Stage 0, x^2 + y^2
    mag_square_sum mag_square_sum_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .x     (ui_in),
        .y     (uio_in),
        .sumsq (sumsq)
    );

    // Stages 1..8, one root bit each
    mag_isqrt mag_isqrt_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .sumsq (sumsq),
        .root  (root)
    );

    assign uo_out  = root;   // Already registered in the last stage
    assign uio_out = '0;
    assign uio_oe  = '0;

    // Ena is always high when powered
    wire unused_ok = &{ena, 1'b0};

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/mag_pkg.sv
hw/mag_square_sum.sv
hw/mag_root_stage.sv
hw/mag_isqrt.sv
hw/tt_um_addon.sv
verif/mag_assertions.sv
verif/tb_tt_um_addon.sv

// ==== verif/mag_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mag_settings.svh"

module mag_assertions (
    input wire logic       clk,
    input wire logic       rst_n,
    input wire logic [7:0] ui_in,    // x component
    input wire logic [7:0] uio_in,   // y component
    input wire logic [7:0] uo_out,   // Length result
    input wire logic [7:0] uio_out,
    input wire logic [7:0] uio_oe
);

    int fail_count = 0;   // Failed assertions so far

    // All uio pins are inputs
    a_uio_oe_zero : assert property (
        @(posedge clk) uio_oe == 8'h00
    ) else begin
        $error("uio_oe is not zero, a uio pin was turned into an output");
        fail_count++;
    end

    a_uio_out_zero : assert property (
        @(posedge clk) uio_out == 8'h00
    ) else begin
        $error("uio_out is not zero");
        fail_count++;
    end

    // Async reset clears the last root stage
    a_reset_clears_out : assert property (
        @(posedge clk) !rst_n |-> (uo_out == 8'h00)
    ) else begin
        $error("uo_out is not zero while rst_n is low");
        fail_count++;
    end

    // Flushed pipeline holds zero for a full latency after release
    a_flush_zero : assert property (
        @(posedge clk)
        ($rose(rst_n) && ui_in == 8'h00 && uio_in == 8'h00)
            |-> (uo_out == 8'h00) [*`MAG_LATENCY]
    ) else begin
        $error("uo_out left zero before the first pair could reach it");
        fail_count++;
    end

    // Result is always a known value once out of reset
    a_out_known : assert property (
        @(posedge clk) rst_n |-> !$isunknown(uo_out)
    ) else begin
        $error("uo_out has X or Z bits after reset");
        fail_count++;
    end

endmodule

bind tt_um_addon mag_assertions mag_assertions_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .ui_in   (ui_in),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
);

`default_nettype wire

// ==== verif/tb_tt_um_addon.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mag_settings.svh"

module tb_tt_um_addon;

    localparam int clk_period   = 8;    // ns
    localparam int reset_cycles = 10;
    localparam int drive_delay  = 1;    // ns after the rising edge
    localparam int num_random   = 200;
    localparam int drain_limit  = 4 * `MAG_LATENCY;  // Generous bound on the drain
    localparam int root_max     = (1 << `MAG_ROOT_W) - 1;

    // One vector and the length it should give
    typedef struct packed {
        logic [`MAG_IN_W-1:0]   x;
        logic [`MAG_IN_W-1:0]   y;
        logic [`MAG_ROOT_W-1:0] root;
    } vec_entry_t;

    localparam int num_entries = 16;

    // Directed vectors, x, y, expected length
    localparam vec_entry_t vec_table [num_entries] = '{
        '{8'd3,   8'd4,   8'd5},      // Pythagorean triples
        '{8'd5,   8'd12,  8'd13},
        '{8'd0,   8'd0,   8'd0},
        '{8'd1,   8'd1,   8'd1},      // sqrt(2) floors to 1
        '{8'd200, 8'd100, 8'd223},
        '{8'd180, 8'd180, 8'd254},    // Just under the limit
        '{8'd255, 8'd0,   8'd255},
        '{8'd255, 8'd255, 8'd255},    // Sum 130050, saturates
        '{8'd0,   8'd255, 8'd255},
        '{8'd6,   8'd8,   8'd10},
        '{8'd7,   8'd24,  8'd25},
        '{8'd20,  8'd21,  8'd29},
        '{8'd128, 8'd128, 8'd181},
        '{8'd2,   8'd2,   8'd2},
        '{8'd181, 8'd181, 8'd255},    // Sum 65522, fits 16 bits
        '{8'd182, 8'd182, 8'd255}     // Sum 66248, wraps if only 16 bits
    };

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    vec_entry_t exp_q [$];   // Pairs in flight, oldest first
    integer     seed;        // $random state

    tt_um_addon tt_um_addon_inst (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // floor(sqrt(x^2 + y^2)) by bit search over a wider range, then clipped
    function automatic logic [`MAG_ROOT_W-1:0] model_length(
        input logic [`MAG_IN_W-1:0] x,
        input logic [`MAG_IN_W-1:0] y
    );
        int sum;
        int r;
        int cand;
        sum = int'(x) * int'(x) + int'(y) * int'(y);
        r   = 0;
        for (int b = `MAG_ROOT_W + 1; b >= 0; b--) begin
            cand = r + (1 << b);
            if (cand * cand <= sum) begin
                r = cand;   // Keep the bit
            end
        end
        if (r > root_max) begin
            r = root_max;   // Length above 255 clips
        end
        return r[`MAG_ROOT_W-1:0];
    endfunction

    task automatic stop_on_failure(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Bound checks count their failures
    always @(tt_um_addon_inst.mag_assertions_inst.fail_count) begin
        if (tt_um_addon_inst.mag_assertions_inst.fail_count != 0) begin
            stop_on_failure("An assertion on the DUT pins failed, see the message above");
        end
    end

    task automatic check_root(
        input logic [`MAG_ROOT_W-1:0] got,
        input logic [`MAG_ROOT_W-1:0] exp,
        input string                  what
    );
        if (got !== exp) begin
            stop_on_failure($sformatf("ERROR at %0t ns: %s, uo_out %0d, expected %0d",
                                      $time, what, got, exp));
        end
    endtask

    task automatic check_pins(
        input logic [7:0] out_v,
        input logic [7:0] oe_v
    );
        if (out_v !== 8'h00) begin
            stop_on_failure($sformatf("ERROR at %0t ns: uio_out is %h, expected 00",
                                      $time, out_v));
        end
        if (oe_v !== 8'h00) begin
            stop_on_failure($sformatf("ERROR at %0t ns: uio_oe is %h, expected 00",
                                      $time, oe_v));
        end
    endtask

    // One cycle: check the oldest pair at the output, then drive the next
    task automatic stream_step(input logic push, input vec_entry_t e);
        vec_entry_t head;
        @(posedge clk);
        #(drive_delay);                 // Output settled since the edge
        check_pins(uio_out, uio_oe);
        head = exp_q.pop_front();
        check_root(uo_out, head.root, $sformatf("x=%0d y=%0d", head.x, head.y));
        if (push) begin
            ui_in  = e.x;
            uio_in = e.y;
            exp_q.push_back(e);         // Due MAG_LATENCY steps from now
        end else begin
            ui_in  = '0;                // Idle, not tracked
            uio_in = '0;
        end
    endtask

    task automatic run_reset();
        int cycles;
        cycles = 0;
        #(drive_delay);
        rst_n  = 1'b0;                  // Real falling edge clears every stage
        while (cycles < reset_cycles) begin
            @(posedge clk);
            #(drive_delay);
            check_root(uo_out, '0, "during reset");
            check_pins(uio_out, uio_oe);
            cycles++;
        end
        rst_n = 1'b1;
        // Flushed stages give zero until the first pair arrives
        for (int i = 0; i < `MAG_LATENCY; i++) begin
            exp_q.push_back('0);
        end
    endtask

    task automatic drain_pipeline();
        int         waited;
        vec_entry_t idle;
        waited = 0;
        idle   = '0;
        while (exp_q.size() > 0) begin
            if (waited >= drain_limit) begin
                stop_on_failure($sformatf(
                    "Pipeline did not drain, %0d results pending after %0d cycles",
                    exp_q.size(), waited));
            end
            stream_step(1'b0, idle);
            waited++;
        end
    endtask

    initial begin
        vec_entry_t  e;
        logic [31:0] rnd;
        seed        = 32'h8153;
        rst_n       = 1'b1;
        ena         = 1'b1;
        ui_in       = '0;
        uio_in      = '0;

        run_reset();

        // Table back to back, one pair per cycle
        for (int i = 0; i < num_entries; i++) begin
            stream_step(1'b1, vec_table[i]);
        end

        // Random pairs follow without a gap
        for (int i = 0; i < num_random; i++) begin
            rnd    = $random(seed);
            e.x    = rnd[7:0];
            e.y    = rnd[15:8];
            e.root = model_length(e.x, e.y);
            stream_step(1'b1, e);
        end

        drain_pipeline();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
